// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
rtl/adc_deser_pkg.sv
rtl/frame_ctrl_if.sv
rtl/frame_sequencer.sv
rtl/adc_lane_capture.sv
rtl/spi_register_port.sv
rtl/frame_result_stage.sv
rtl/adc_spi_deser_top.sv
tb/adc_slave_model.sv
tb/tb_top.sv

// File: rtl/adc_deser_pkg.sv
// Frame constants, phase-select and frame-kind types, SPI frame union, window shift helper
package adc_deser_pkg;

    localparam int LANE_BITS    = 12;                        // Bits per lane per sample
    localparam int NUM_LANES    = 4;                         // Data lanes A to D
    localparam int SAMPLE_BITS  = LANE_BITS * NUM_LANES;     // Assembled sample, 48 bits
    localparam int SPI_BITS     = 24;                        // Register frame width
    localparam int ADDR_BITS    = 8;                         // Register address field
    localparam int DATA_BITS    = SPI_BITS - ADDR_BITS;      // Register data field
    localparam int GUARD_BITS   = 3;                         // Extra bit periods for phase window
    localparam int BIT_CYCLES   = 2;                         // Clocks per bit period
    localparam int FRAME_GAP    = 4;                         // CS_Z high cycles between captures

    localparam int LANE_SR_BITS = LANE_BITS + GUARD_BITS;    // Over-sampled lane register
    localparam int SPI_SR_BITS  = SPI_BITS + GUARD_BITS;     // Over-sampled readback register
    localparam int BIT_CNT_W    = $clog2(SPI_SR_BITS);       // Holds longest bit-period countdown
    localparam int CYC_W        = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
    localparam int GAP_W        = $clog2(FRAME_GAP);

    typedef logic [1:0] phase_sel_t;                         // Per-lane window code

    typedef enum logic [1:0] {
        KIND_CAPTURE = 2'd0,                                 // ADC sample frame
        KIND_WRITE   = 2'd1,                                 // Register write on MOSI
        KIND_READ    = 2'd2                                  // Register readback on lane A
    } frame_kind_t;

    typedef union packed {
        logic [SPI_BITS-1:0] raw;                            // Shift-register view
        struct packed {
            logic [ADDR_BITS-1:0] addr;                      // Sent first
            logic [DATA_BITS-1:0] data;
        } fields;
    } spi_frame_u;

    // Right shift that drops the late guard samples; code 3 keeps the earliest window
    function automatic logic [1:0] window_shift(phase_sel_t code);
        case (code)
            2'd3:    return 2'd3;                            // Lag 0
            2'd0:    return 2'd2;                            // Lag 1
            2'd1:    return 2'd1;                            // Lag 2
            default: return 2'd0;                            // Lag 3
        endcase
    endfunction

endpackage

// File: rtl/adc_lane_capture.sv
`timescale 1ns/1ps
// Four-lane capture: over-sampled shift registers, per-lane phase window and 48-bit assembly
module adc_lane_capture
    import adc_deser_pkg::*;
(
    input  logic                   sclk_del_clk,
    input  logic                   rst,
    input  logic                   din_a,
    input  logic                   din_b,
    input  logic                   din_c,
    input  logic                   din_d,
    input  phase_sel_t             phase_a,
    input  phase_sel_t             phase_b,
    input  phase_sel_t             phase_c,
    input  phase_sel_t             phase_d,
    frame_ctrl_if.capture          ctl,
    output logic [SAMPLE_BITS-1:0] sample_word
);

    logic [NUM_LANES-1:0]       din;                 // Index 3 is lane A
    phase_sel_t [NUM_LANES-1:0] phase;
    logic [LANE_SR_BITS-1:0]    lane_sr [NUM_LANES]; // Earliest sample ends up in the MSB
    logic [LANE_BITS-1:0]       lane_win [NUM_LANES];
    logic                       cap_frame;

    assign din       = {din_a, din_b, din_c, din_d};
    assign phase     = {phase_a, phase_b, phase_c, phase_d};
    assign cap_frame = (ctl.kind == KIND_CAPTURE);   // Register frames leave lanes alone

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_sr[i] <= '0;
            end
        end else if (cap_frame && ctl.load) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_sr[i] <= '0;                    // Fresh frame
            end
        end else if (cap_frame && ctl.sample) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_sr[i] <= {lane_sr[i][LANE_SR_BITS-2:0], din[i]};
            end
        end
    end

    // Valid the cycle after the last sample, held until the next load
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_win[i] = LANE_BITS'(lane_sr[i] >> window_shift(phase[i]));
            sample_word[i*LANE_BITS +: LANE_BITS] = lane_win[i];   // Lane A lands on top
        end
    end

endmodule

// File: rtl/adc_spi_deser_top.sv
`timescale 1ns/1ps
// Top level of the serial ADC controller with plain ports and block wiring
module adc_spi_deser_top
    import adc_deser_pkg::*;
(
    input  logic                   sclk_del_clk,
    input  logic                   rst,
    input  logic                   spi_en,      // High for register mode
    input  logic                   wr_start,
    input  logic                   rd_start,
    input  logic [ADDR_BITS-1:0]   wr_addr,
    input  logic [DATA_BITS-1:0]   wr_data,
    input  logic                   din_a,
    input  logic                   din_b,
    input  logic                   din_c,
    input  logic                   din_d,
    input  phase_sel_t             phase_a,
    input  phase_sel_t             phase_b,
    input  phase_sel_t             phase_c,
    input  phase_sel_t             phase_d,
    output logic                   cs_z,
    output logic                   sclk,
    output logic                   mosi,
    output logic                   busy,
    output logic [SAMPLE_BITS-1:0] dout,
    output logic                   drdy,
    output logic [SPI_BITS-1:0]    read_data
);

    logic [SAMPLE_BITS-1:0] sample_word;
    spi_frame_u             rd_word;

    frame_ctrl_if ctl_if ();

    frame_sequencer u_seq (
        .sclk_del_clk (sclk_del_clk),
        .rst          (rst),
        .spi_en       (spi_en),
        .wr_start     (wr_start),
        .rd_start     (rd_start),
        .cs_z         (cs_z),
        .sclk         (sclk),
        .busy         (busy),
        .ctl          (ctl_if.seq)
    );

    adc_lane_capture u_capture (
        .sclk_del_clk (sclk_del_clk),
        .rst          (rst),
        .din_a        (din_a),
        .din_b        (din_b),
        .din_c        (din_c),
        .din_d        (din_d),
        .phase_a      (phase_a),
        .phase_b      (phase_b),
        .phase_c      (phase_c),
        .phase_d      (phase_d),
        .ctl          (ctl_if.capture),
        .sample_word  (sample_word)
    );

    spi_register_port u_regport (
        .sclk_del_clk (sclk_del_clk),
        .rst          (rst),
        .din_a        (din_a),      // Readback shares lane A
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .phase_a      (phase_a),
        .ctl          (ctl_if.capture),
        .mosi         (mosi),
        .rd_word      (rd_word)
    );

    frame_result_stage u_result (
        .sclk_del_clk (sclk_del_clk),
        .rst          (rst),
        .sample_word  (sample_word),
        .rd_word      (rd_word),
        .ctl          (ctl_if.result),
        .dout         (dout),
        .drdy         (drdy),
        .read_data    (read_data)
    );

endmodule

// File: rtl/frame_ctrl_if.sv
`timescale 1ns/1ps
// Frame control interface: kind, CS-low window and per-frame strobes with three modports
interface frame_ctrl_if
    import adc_deser_pkg::*;
();

    frame_kind_t kind;        // Frame type, stable from load through done
    logic        active;      // High while CS_Z is low
    logic        sample;      // Last cycle of each bit period
    logic        sclk_fall;   // SCLK goes low at the end of this cycle
    logic        load;        // Cycle before bit period 0
    logic        done;        // First cycle with CS_Z high again

    // Sequencer owns every strobe
    modport seq (
        output kind, active, sample, sclk_fall, load, done
    );

    // Capture paths watch the whole frame
    modport capture (
        input kind, active, sample, sclk_fall, load, done
    );

    // Result stage only needs the end of frame
    modport result (
        input kind, done
    );

endinterface

// File: rtl/frame_result_stage.sv
`timescale 1ns/1ps
// Result stage: registers capture word with DRDY or readback word at end of frame
module frame_result_stage
    import adc_deser_pkg::*;
(
    input  logic                   sclk_del_clk,
    input  logic                   rst,
    input  logic [SAMPLE_BITS-1:0] sample_word,
    input  spi_frame_u             rd_word,
    frame_ctrl_if.result           ctl,
    output logic [SAMPLE_BITS-1:0] dout,
    output logic                   drdy,
    output logic [SPI_BITS-1:0]    read_data
);

    logic cap_done;
    logic rd_done;

    assign cap_done = ctl.done && (ctl.kind == KIND_CAPTURE);
    assign rd_done  = ctl.done && (ctl.kind == KIND_READ);   // Write frames leave outputs as is

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            drdy      <= 1'b0;
            dout      <= '0;
            read_data <= '0;
        end else begin
            drdy <= cap_done;                                 // Single cycle, DOUT moves with it
            if (cap_done) begin
                dout <= sample_word;                          // Held until next DRDY
            end
            if (rd_done) begin
                read_data <= {rd_word.fields.addr, rd_word.fields.data};
            end
        end
    end

    a_drdy_single: assert property (@(posedge sclk_del_clk) disable iff (rst)
        drdy |=> !drdy);

endmodule

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ps
// Frame sequencer: spi_en synchronizer, start acceptance, bit-period countdown, CS_Z, SCLK, strobes
module frame_sequencer
    import adc_deser_pkg::*;
(
    input  logic       sclk_del_clk,
    input  logic       rst,
    input  logic       spi_en,
    input  logic       wr_start,
    input  logic       rd_start,
    output logic       cs_z,
    output logic       sclk,
    output logic       busy,
    frame_ctrl_if.seq  ctl
);

    logic [1:0]           spi_en_sync;   // Two-flop synchronizer
    logic                 spi_en_s;
    logic                 idle;
    logic                 cap_req;       // Capture mode wants another frame
    logic                 wr_acc;
    logic                 rd_acc;
    logic                 accept;
    logic [BIT_CNT_W-1:0] frame_n;       // Payload bits of current kind
    logic [BIT_CNT_W-1:0] bits_left;     // Bit periods remaining after this one
    logic [CYC_W-1:0]     cyc;           // Cycle within bit period
    logic                 last_cyc;
    logic                 sclk_window;   // Bit periods 1 to N
    logic [GAP_W-1:0]     gap_cnt;
    logic                 gap_last;
    logic                 in_gap;
    logic                 load_q;
    logic                 done_q;
    logic                 sclk_q;
    logic                 cs_z_q;
    logic                 busy_q;
    frame_kind_t          kind_q;

    assign spi_en_s = spi_en_sync[1];
    assign idle     = cs_z_q && !load_q && !in_gap;
    assign cap_req  = idle && !spi_en_s;                      // Level driven, repeats each frame
    assign wr_acc   = idle && spi_en_s && wr_start;
    assign rd_acc   = idle && spi_en_s && rd_start && !wr_start;   // Write wins a tie
    assign accept   = cap_req || wr_acc || rd_acc;

    assign frame_n  = (kind_q == KIND_CAPTURE) ? BIT_CNT_W'(LANE_BITS) : BIT_CNT_W'(SPI_BITS);
    assign last_cyc = (cyc == CYC_W'(BIT_CYCLES - 1));
    // Countdown runs N+2 .. 0, so period 1 is N+1 and period N is 2
    assign sclk_window = (bits_left <= frame_n + BIT_CNT_W'(GUARD_BITS - 2)) &&
                         (bits_left >= BIT_CNT_W'(GUARD_BITS - 1));
    // Register frames release the port right after done
    assign gap_last = (kind_q != KIND_CAPTURE) || (gap_cnt == GAP_W'(FRAME_GAP - 3));

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            spi_en_sync <= 2'b11;                             // Come up in register mode
        end else begin
            spi_en_sync <= {spi_en_sync[0], spi_en};
        end
    end

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            kind_q    <= KIND_CAPTURE;
            load_q    <= 1'b0;
            cs_z_q    <= 1'b1;
            sclk_q    <= 1'b0;
            done_q    <= 1'b0;
            busy_q    <= 1'b0;
            in_gap    <= 1'b0;
            gap_cnt   <= '0;
            bits_left <= '0;
            cyc       <= '0;
        end else begin
            load_q <= accept;                                 // Load one cycle before CS_Z low
            done_q <= 1'b0;
            sclk_q <= 1'b0;
            if (accept) begin
                busy_q <= 1'b1;
                kind_q <= cap_req ? KIND_CAPTURE : (wr_acc ? KIND_WRITE : KIND_READ);
            end else if (done_q) begin
                busy_q <= 1'b0;                               // Drops as the result lands
            end
            if (load_q) begin
                cs_z_q    <= 1'b0;
                bits_left <= frame_n + BIT_CNT_W'(GUARD_BITS - 1);
                cyc       <= '0;
            end else if (!cs_z_q) begin
                if (last_cyc) begin
                    cyc <= '0;
                    if (bits_left == '0) begin
                        cs_z_q  <= 1'b1;                      // End of frame
                        done_q  <= 1'b1;
                        in_gap  <= 1'b1;
                        gap_cnt <= '0;
                    end else begin
                        bits_left <= bits_left - 1'b1;
                    end
                end else begin
                    cyc    <= cyc + 1'b1;
                    // SCLK high only in the final cycle of the period
                    sclk_q <= sclk_window && (cyc == CYC_W'(BIT_CYCLES - 2));
                end
            end else if (in_gap) begin
                gap_cnt <= gap_cnt + 1'b1;
                if (gap_last) begin
                    in_gap <= 1'b0;
                end
            end
        end
    end

    assign ctl.kind      = kind_q;
    assign ctl.active    = !cs_z_q;
    assign ctl.sample    = !cs_z_q && last_cyc;               // Same edge that drops SCLK
    assign ctl.sclk_fall = sclk_q;
    assign ctl.load      = load_q;
    assign ctl.done      = done_q;

    assign cs_z = cs_z_q;
    assign sclk = sclk_q;
    assign busy = busy_q;

    a_sclk_inside_cs: assert property (@(posedge sclk_del_clk) disable iff (rst)
        sclk_q |-> !cs_z_q);
    a_no_start_while_busy: assert property (@(posedge sclk_del_clk) disable iff (rst)
        (wr_acc || rd_acc) |-> !busy_q);

endmodule

// File: rtl/spi_register_port.sv
`timescale 1ns/1ps
// Register port with MOSI serializer for writes and lane-A readback window for reads
module spi_register_port
    import adc_deser_pkg::*;
(
    input  logic                 sclk_del_clk,
    input  logic                 rst,
    input  logic                 din_a,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  logic [DATA_BITS-1:0] wr_data,
    input  phase_sel_t           phase_a,
    frame_ctrl_if.capture        ctl,
    output logic                 mosi,
    output spi_frame_u           rd_word
);

    spi_frame_u             wr_frame;
    logic [SPI_BITS-1:0]    tx_sr;        // MSB is on the wire
    logic [SPI_SR_BITS-1:0] rx_sr;        // Readback with guard samples
    logic                   wr_sel;
    logic                   rd_sel;

    assign wr_sel = (ctl.kind == KIND_WRITE);
    assign rd_sel = (ctl.kind == KIND_READ);

    // Address goes out ahead of data
    assign wr_frame.fields = '{addr: wr_addr, data: wr_data};

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            tx_sr <= '0;
        end else if (wr_sel && ctl.load) begin
            tx_sr <= wr_frame.raw;
        end else if (wr_sel && ctl.sclk_fall) begin
            tx_sr <= {tx_sr[SPI_BITS-2:0], 1'b0};    // Next bit on SCLK fall
        end
    end

    assign mosi = ctl.active && wr_sel && tx_sr[SPI_BITS-1];   // Parked low outside write frames

    always_ff @(posedge sclk_del_clk or posedge rst) begin
        if (rst) begin
            rx_sr <= '0;
        end else if (rd_sel && ctl.load) begin
            rx_sr <= '0;
        end else if (rd_sel && ctl.sample) begin
            rx_sr <= {rx_sr[SPI_SR_BITS-2:0], din_a};
        end
    end

    // Lane A code picks the window as for the data lanes
    assign rd_word.raw = SPI_BITS'(rx_sr >> window_shift(phase_a));

    // Every frame bit has left the serializer once the write frame ends
    a_tx_empty_at_done: assert property (@(posedge sclk_del_clk) disable iff (rst)
        (ctl.done && wr_sel) |-> (tx_sr == '0));

endmodule

// File: tb/adc_slave_model.sv
`timescale 1ns/1ps
// Behavioral serial ADC: lagged lane words on din_a to din_d, SCLK count and MOSI recorder
module adc_slave_model
    import adc_deser_pkg::*;
(
    input  logic                     sclk_del_clk,
    input  logic                     cs_z,
    input  logic                     sclk,
    input  logic                     mosi,
    input  logic [0:3][SPI_BITS-1:0] words,       // Lane A first, MSB goes out first
    input  logic [0:3][1:0]          lags,        // Bit period that carries each lane's MSB
    input  int                       word_bits,   // 12 for samples, 24 for readback
    output logic                     din_a,
    output logic                     din_b,
    output logic                     din_c,
    output logic                     din_d,
    output int                       frame_cnt,   // CS_Z falling edges seen
    output int                       sclk_last,   // SCLK rises in the latest frame
    output int                       sclk_stray,  // SCLK rises while CS_Z is high
    output logic [SPI_BITS-1:0]      mosi_word    // MOSI bits of the latest frame
);

    int         cyc;                              // Cycles since CS_Z fell
    logic       cs_prev;
    logic       sclk_prev;
    logic [0:3] lane_out;

    function automatic logic lane_bit(input logic [SPI_BITS-1:0] w, input logic [1:0] lag,
                                      input int period);
        int idx;
        idx = period - int'(lag);
        if (idx < 0 || idx >= word_bits) begin
            return 1'b0;                          // Guard periods read as zero
        end
        return w[word_bits - 1 - idx];
    endfunction

    initial begin
        lane_out   = '0;
        {din_a, din_b, din_c, din_d} = 4'b0;
        frame_cnt  = 0;
        sclk_last  = 0;
        sclk_stray = 0;
        mosi_word  = '0;
        cyc        = 0;
        cs_prev    = 1'b1;
        sclk_prev  = 1'b0;
        forever begin
            @(posedge sclk_del_clk);
            #1;                                   // DUT registers have settled
            if (!cs_z) begin
                if (cs_prev) begin                // New frame
                    frame_cnt++;
                    sclk_last = 0;
                    mosi_word = '0;
                    cyc       = 0;
                end else begin
                    cyc++;
                end
                // Bit-period boundary, the SCLK fall inside the window
                if (cyc % BIT_CYCLES == 0) begin
                    for (int i = 0; i < 4; i++) begin
                        lane_out[i] = lane_bit(words[i], lags[i], cyc / BIT_CYCLES);
                    end
                end
                if (sclk && !sclk_prev) begin     // MOSI is stable while SCLK is high
                    sclk_last++;
                    mosi_word = {mosi_word[SPI_BITS-2:0], mosi};
                end
            end else begin
                lane_out = '0;
                if (sclk && !sclk_prev) begin
                    sclk_stray++;
                end
            end
            {din_a, din_b, din_c, din_d} = lane_out;
            cs_prev   = cs_z;
            sclk_prev = sclk;
        end
    end

endmodule

// File: tb/deser_stimulus.txt
# kind phase_a phase_b phase_c phase_d word_a word_b word_c word_d expected, all hex
# kind 0 capture, 1 write (word_a addr, word_b data), 2 read (word_a readback), 3 continuous
0 3 3 3 3 a5c 3f1 96e 0b7 a5c3f196e0b7
0 0 1 2 3 123 fed 8a1 5e6 123fed8a15e6
1 3 3 3 3 5a c3e1 0 0 5ac3e1
1 3 3 3 3 81 007f 0 0 81007f
2 1 3 3 3 b4d27e 0 0 0 b4d27e
2 3 3 3 3 0f1e2d 0 0 0 0f1e2d
2 2 3 3 3 9a3b51 0 0 0 9a3b51
3 3 0 1 2 7c1 2a9 e04 5b3 7c12a9e045b3
3 2 2 2 2 001 fff 800 7ff 001fff8007ff
3 1 3 0 2 6d4 b92 13a c5f 6d4b9213ac5f
0 0 0 0 0 d0e 1f2 a3b 4c6 d0e1f2a3b4c6

// File: tb/tb_top.sv
`timescale 1ns/1ps
// Testbench top: clock, reset, file-driven capture and register tests, value check and summary
module tb_top
    import adc_deser_pkg::*;
();

    localparam int WAIT_LIMIT = 400;              // Cycles before any wait gives up
    localparam int SEL_BUSY   = 0;
    localparam int SEL_CS_Z   = 1;
    localparam int SEL_DRDY   = 2;

    logic                     sclk_del_clk;
    logic                     rst;
    logic                     spi_en;
    logic                     wr_start;
    logic                     rd_start;
    logic [ADDR_BITS-1:0]     wr_addr;
    logic [DATA_BITS-1:0]     wr_data;
    logic                     din_a, din_b, din_c, din_d;
    phase_sel_t               phase_a, phase_b, phase_c, phase_d;
    logic                     cs_z, sclk, mosi, busy, drdy;
    logic [SAMPLE_BITS-1:0]   dout;
    logic [SPI_BITS-1:0]      read_data;
    logic [0:3][SPI_BITS-1:0] words;              // ADC model lane words
    logic [0:3][1:0]          lags;
    int                       word_bits;
    int                       frame_cnt, sclk_last, sclk_stray;
    logic [SPI_BITS-1:0]      mosi_word;
    int                       errors, test_errors, checks, tests;
    bit                       streaming;          // spi_en held low across lines
    logic [SAMPLE_BITS-1:0]   last_exp;

    adc_spi_deser_top u_dut (.*);
    adc_slave_model   u_model (.*);

    initial begin
        sclk_del_clk = 1'b0;
        forever #10 sclk_del_clk = ~sclk_del_clk;    // 20 ns period
    end

    initial begin
        #2_000_000;                               // Hard stop for a stuck run
        $display("simulation time limit reached before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic next_cycle();
        @(posedge sclk_del_clk);
        #2;                                       // Drive and sample clear of the edge
    endtask

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SEL_BUSY: return busy;
            SEL_CS_Z: return cs_z;
            default:  return drdy;
        endcase
    endfunction

    task automatic wait_level(input string what, input int sel, input logic level, output bit ok);
        int n;
        n = 0;
        while (probe(sel) !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        ok = (probe(sel) === level);
        if (!ok) begin
            $display("timeout at %0t: %s did not happen in %0d cycles", $time, what, WAIT_LIMIT);
            errors++;
            test_errors++;
        end
    endtask

    // Code 3 is lag 0, then 0, 1, 2 add one bit period each
    function automatic logic [1:0] lag_for_code(input phase_sel_t code);
        return code + 2'd1;
    endfunction

    task automatic set_lanes(input phase_sel_t pa, pb, pc, pd,
                             input logic [SPI_BITS-1:0] wa, wb, wc, wd, input int nbits);
        {phase_a, phase_b, phase_c, phase_d} = {pa, pb, pc, pd};
        words     = {wa, wb, wc, wd};
        lags      = {lag_for_code(pa), lag_for_code(pb), lag_for_code(pc), lag_for_code(pd)};
        word_bits = nbits;
    endtask

    task automatic capture_frame(input logic [SAMPLE_BITS-1:0] expv);
        bit ok;
        last_exp = expv;
        if (!streaming) begin
            spi_en    = 1'b0;                     // Start continuous capture
            streaming = 1'b1;
        end
        wait_level("DRDY pulse", SEL_DRDY, 1'b1, ok);
        if (ok) begin
            check_value("DOUT at DRDY", 64'(dout), 64'(expv));
            check_value("SCLK pulses in capture frame", 64'(sclk_last), 64'(LANE_BITS));
            check_value("CS_Z high at DRDY", 64'(cs_z), 64'(1));
            next_cycle();                         // Step past this DRDY
        end
    endtask

    task automatic stop_capture();
        int idle_run;
        int n;
        int frames;
        spi_en    = 1'b1;
        streaming = 1'b0;
        idle_run  = 0;
        n         = 0;
        while (idle_run < 8 && n < WAIT_LIMIT) begin    // Frame in flight still finishes
            next_cycle();
            n++;
            idle_run = (cs_z && !busy) ? idle_run + 1 : 0;
            if (drdy) begin
                check_value("DOUT of trailing frame", 64'(dout), 64'(last_exp));
            end
        end
        if (idle_run < 8) begin
            $display("timeout at %0t: capture did not stop after spi_en rose", $time);
            errors++;
            test_errors++;
        end
        frames = frame_cnt;
        repeat (3 * BIT_CYCLES * LANE_SR_BITS) next_cycle();
        check_value("frames after spi_en high", 64'(frame_cnt), 64'(frames));
    endtask

    task automatic pulse_start(input bit rd);
        if (rd) rd_start = 1'b1;
        else    wr_start = 1'b1;
        next_cycle();
        rd_start = 1'b0;
        wr_start = 1'b0;
    endtask

    task automatic write_test(input logic [SPI_BITS-1:0] addr, data, exp);
        bit ok;
        int frames;
        wr_addr = addr[ADDR_BITS-1:0];
        wr_data = data[DATA_BITS-1:0];
        frames  = frame_cnt;
        pulse_start(1'b0);
        wait_level("busy after wr_start", SEL_BUSY, 1'b1, ok);
        if (ok) wait_level("CS_Z low for write", SEL_CS_Z, 1'b0, ok);
        if (ok) begin
            pulse_start(1'b0);                    // Lands while busy, must be dropped
            wait_level("busy low after write", SEL_BUSY, 1'b0, ok);
        end
        if (ok) begin
            repeat (20) next_cycle();             // Room for a stray frame to show up
            check_value("write frame count", 64'(frame_cnt - frames), 64'(1));
            check_value("SCLK pulses in write frame", 64'(sclk_last), 64'(SPI_BITS));
            check_value("MOSI word", 64'(mosi_word), 64'(exp));
            check_value("busy after write", 64'(busy), 64'(0));
        end
    endtask

    task automatic read_test(input logic [SPI_BITS-1:0] exp);
        bit ok;
        pulse_start(1'b1);
        wait_level("busy after rd_start", SEL_BUSY, 1'b1, ok);
        if (ok) wait_level("busy low after read", SEL_BUSY, 1'b0, ok);
        if (ok) check_value("read_data at busy fall", 64'(read_data), 64'(exp));
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (test_errors == 0) ? "ok" : "failed");
        test_errors = 0;
    endtask

    initial begin
        int                     fd;
        int                     kind;
        int                     n;
        string                  line;
        string                  name;
        phase_sel_t             pa, pb, pc, pd;
        logic [SPI_BITS-1:0]    w0, w1, w2, w3;
        logic [SAMPLE_BITS-1:0] expv;
        $timeformat(-9, 0, " ns", 0);
        {errors, test_errors, checks, tests} = '0;
        rst       = 1'b1;
        spi_en    = 1'b1;                         // Register mode until a capture line
        wr_start  = 1'b0;
        rd_start  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        streaming = 1'b0;
        last_exp  = '0;
        set_lanes(2'd3, 2'd3, 2'd3, 2'd3, '0, '0, '0, '0, LANE_BITS);
        repeat (5) @(posedge sclk_del_clk);
        #2;
        rst = 1'b0;
        next_cycle();
        check_value("CS_Z after reset", 64'(cs_z), 64'(1));
        check_value("SCLK after reset", 64'(sclk), 64'(0));
        check_value("MOSI after reset", 64'(mosi), 64'(0));
        check_value("DRDY after reset", 64'(drdy), 64'(0));
        check_value("busy after reset", 64'(busy), 64'(0));
        finish_test("reset state");
        fd = $fopen("tb/deser_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/deser_stimulus.txt");
            errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;   // Blank or column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        kind, pa, pb, pc, pd, w0, w1, w2, w3, expv);
            if (n != 10) begin
                $display("stimulus line could not be read: %s", line);
                errors++;
                continue;
            end
            if (streaming && kind != 3) stop_capture();
            case (kind)
                0, 3: begin
                    name = (kind == 0) ? "capture" : "continuous capture";
                    set_lanes(pa, pb, pc, pd, w0, w1, w2, w3, LANE_BITS);
                    capture_frame(expv);
                    if (kind == 0) stop_capture();
                end
                1: begin
                    name = "register write";
                    set_lanes(pa, pb, pc, pd, '0, '0, '0, '0, SPI_BITS);
                    write_test(w0, w1, expv[SPI_BITS-1:0]);
                end
                2: begin
                    name = "register read";
                    set_lanes(pa, pb, pc, pd, w0, '0, '0, '0, SPI_BITS);
                    read_test(expv[SPI_BITS-1:0]);
                end
                default: begin
                    name = "unknown kind";
                    $display("stimulus line has an unknown test kind %0d", kind);
                    errors++;
                    test_errors++;
                end
            endcase
            finish_test(name);
        end
        if (streaming) stop_capture();
        check_value("SCLK rises outside CS_Z low", 64'(sclk_stray), 64'(0));
        if (fd != 0) $fclose(fd);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
